//--- design/periph_xbar_cfg.svh
// ----------------------------------------------------------
// sizes and address map of the peripheral crossbar
// the routing field must be exactly as wide as the slave index
// ----------------------------------------------------------
`ifndef PERIPH_XBAR_CFG_SVH
`define PERIPH_XBAR_CFG_SVH

// port counts
`define XBAR_NB_MASTERS 4
`define XBAR_NB_SLAVES 8

// bus widths
`define XBAR_ADDR_WIDTH 32
`define XBAR_DATA_WIDTH 32
`define XBAR_BE_WIDTH 4

// address bits that select the slave lane
`define XBAR_ROUTING_LSB 10
`define XBAR_ROUTING_MSB 12

// cluster 0 map, each cluster id step adds 4 MiB
`define XBAR_CLUSTER_BASE 32'h1000_0000
`define XBAR_PERIPH_OFFS 32'h0020_0000
`define XBAR_EXT_OFFS 32'h0040_0000

// alias window, matched on the top address byte only
`define XBAR_ALIAS_EN 1'b1
`define XBAR_ALIAS_TOP 8'h1B

// accelerator slot populated
`define XBAR_HWPE_PRESENT 1'b1

`endif

//--- design/periph_xbar_pkg.sv
// ----------------------------------------------------------
// payload types and fixed slot numbers of the crossbar
// slot numbers must stay below XBAR_NB_SLAVES
// ----------------------------------------------------------
`include "periph_xbar_cfg.svh"

package periph_xbar_pkg;

  // slave lane number, as wide as the routing field
  typedef logic [`XBAR_ROUTING_MSB-`XBAR_ROUTING_LSB:0] slv_idx_t;

  // one bit per master, echoed back with the response
  typedef logic [`XBAR_NB_MASTERS-1:0] mst_id_t;

  // request as it travels through an arbiter lane
  typedef struct packed {
    logic [`XBAR_ADDR_WIDTH-1:0] addr;
    logic [`XBAR_DATA_WIDTH-1:0] data;
    mst_id_t                     id;
    logic                        we_n;
    logic [`XBAR_BE_WIDTH-1:0]   be;
  } xbar_req_t;

  // response of one slave lane
  typedef struct packed {
    logic [`XBAR_DATA_WIDTH-1:0] data;
    mst_id_t                     id;
    logic                        opc;
  } xbar_resp_t;

  // event unit occupies EU_PLUGS consecutive slots
  localparam slv_idx_t SLV_EU_ID = 3'd2;
  localparam int unsigned EU_PLUGS = 2;

  // accelerator slot
  localparam slv_idx_t SLV_HWPE_ID = 3'd4;

  // everything outside the cluster window
  localparam slv_idx_t SLV_EXT_ID = 3'd6;

  // malformed or forbidden accesses end here
  localparam slv_idx_t SLV_ERR_ID = 3'd7;

endpackage

//--- design/periph_addr_decoder.sv
// ----------------------------------------------------------
// purely combinational, only the first 64 KiB of the window decode
// alias window is checked on the top byte, the rest as in the cluster
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_addr_decoder (
  input  logic [`XBAR_ADDR_WIDTH-1:0] addr_i,
  input  logic [5:0]                  cluster_id_i,
  output periph_xbar_pkg::slv_idx_t   slv_idx_o
);

  localparam int unsigned CLUSTER_SHIFT = 22;
  localparam int unsigned TOP_LSB = `XBAR_ADDR_WIDTH - 8;
  localparam int unsigned CHECK_MSB = 19;

  logic [`XBAR_ADDR_WIDTH-1:0] cluster_base;
  logic [`XBAR_ADDR_WIDTH-1:0] periph_base;
  logic [`XBAR_ADDR_WIDTH-1:0] periph_end;
  logic [`XBAR_ADDR_WIDTH-1:0] local_addr;
  logic                        top_hit;
  logic                        in_window;
  logic                        malformed;
  periph_xbar_pkg::slv_idx_t   route_idx;

  // window of this cluster, relocated by the cluster id
  assign cluster_base = `XBAR_CLUSTER_BASE
                      + (`XBAR_ADDR_WIDTH'(cluster_id_i) << CLUSTER_SHIFT);
  assign periph_base  = cluster_base + `XBAR_PERIPH_OFFS;
  assign periph_end   = cluster_base + `XBAR_EXT_OFFS;

  // cluster byte or alias byte on top
  assign top_hit = (addr_i[`XBAR_ADDR_WIDTH-1:TOP_LSB] == cluster_base[`XBAR_ADDR_WIDTH-1:TOP_LSB])
                || (`XBAR_ALIAS_EN && addr_i[`XBAR_ADDR_WIDTH-1:TOP_LSB] == `XBAR_ALIAS_TOP);

  // alias accesses are compared as if they were in the cluster
  assign local_addr = {cluster_base[`XBAR_ADDR_WIDTH-1:TOP_LSB], addr_i[TOP_LSB-1:0]};
  assign in_window  = top_hit && (local_addr >= periph_base) && (local_addr < periph_end);

  assign route_idx = addr_i[`XBAR_ROUTING_MSB:`XBAR_ROUTING_LSB];

  // stray bits above the routing field or a lane that does not exist
  assign malformed = (local_addr[`XBAR_ADDR_WIDTH-1:16] != periph_base[`XBAR_ADDR_WIDTH-1:16])
                  || (addr_i[CHECK_MSB:`XBAR_ROUTING_MSB+1] != '0)
                  || (int'(route_idx) >= `XBAR_NB_SLAVES);

  always_comb begin
    if (!in_window) begin
      slv_idx_o = periph_xbar_pkg::SLV_EXT_ID;
    end else if (malformed) begin
      slv_idx_o = periph_xbar_pkg::SLV_ERR_ID;
    end else if (route_idx >= periph_xbar_pkg::SLV_EU_ID
              && int'(route_idx) < int'(periph_xbar_pkg::SLV_EU_ID)
                                   + periph_xbar_pkg::EU_PLUGS) begin
      // all event unit slots share one port
      slv_idx_o = periph_xbar_pkg::SLV_EU_ID;
    end else if (!`XBAR_HWPE_PRESENT && route_idx == periph_xbar_pkg::SLV_HWPE_ID) begin
      slv_idx_o = periph_xbar_pkg::SLV_ERR_ID;
    end else if (route_idx == periph_xbar_pkg::SLV_EXT_ID) begin
      // direct external slot would loop back out of the cluster
      slv_idx_o = periph_xbar_pkg::SLV_ERR_ID;
    end else begin
      slv_idx_o = route_idx;
    end
  end

endmodule

//--- design/req_demux.sv
// ----------------------------------------------------------
// one master to all lanes, sel_i must be held with req_i
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module req_demux (
  input  logic                        req_i,
  input  periph_xbar_pkg::slv_idx_t   sel_i,
  output logic [`XBAR_NB_SLAVES-1:0]  req_o,
  input  logic [`XBAR_NB_SLAVES-1:0]  gnt_i,
  output logic                        gnt_o
);

  logic [`XBAR_NB_SLAVES-1:0] sel_oh;

  always_comb begin
    for (int s = 0; s < `XBAR_NB_SLAVES; s++) begin
      sel_oh[s] = (int'(sel_i) == s);
    end
  end

  // only the addressed lane sees the request
  assign req_o = sel_oh & {`XBAR_NB_SLAVES{req_i}};

  // grant taken from the addressed lane alone
  assign gnt_o = |(gnt_i & sel_oh);

endmodule

//--- design/rr_arbiter.sv
// ----------------------------------------------------------
// round robin over NUM_IN inputs, pointer moves only on a transfer
// ----------------------------------------------------------
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int unsigned NUM_IN = 4,
  parameter type payload_t = logic
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic     [NUM_IN-1:0] req_i,
  input  payload_t [NUM_IN-1:0] data_i,
  output logic     [NUM_IN-1:0] gnt_o,
  output logic                  req_o,
  output payload_t              data_o,
  input  logic                  gnt_i
);

  localparam int unsigned IDX_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] win_idx;
  logic [IDX_W-1:0] ptr_next;
  logic             found;

  // first requester at or after the pointer, wrapping around
  always_comb begin
    int cand;
    found   = 1'b0;
    win_idx = ptr_q;
    for (int i = 0; i < NUM_IN; i++) begin
      cand = int'(ptr_q) + i;
      if (cand >= NUM_IN) begin
        cand = cand - NUM_IN;
      end
      if (!found && req_i[cand]) begin
        found   = 1'b1;
        win_idx = IDX_W'(cand);
      end
    end
  end

  assign req_o  = found;
  assign data_o = data_i[win_idx];

  // grant goes back to the winner only
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = gnt_i && found;
  end

  // winner drops to lowest priority after it is served
  always_comb begin
    if (win_idx == IDX_W'(NUM_IN - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = win_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (found && gnt_i) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

//--- design/resp_mux.sv
// ----------------------------------------------------------
// at most one lane may answer a given master per cycle
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module resp_mux #(
  parameter int unsigned MST_IDX = 0
) (
  input  logic [`XBAR_NB_SLAVES-1:0]                            r_valid_i,
  input  periph_xbar_pkg::mst_id_t [`XBAR_NB_SLAVES-1:0]        r_id_i,
  input  logic [`XBAR_NB_SLAVES-1:0][`XBAR_DATA_WIDTH-1:0]      r_data_i,
  input  logic [`XBAR_NB_SLAVES-1:0]                            r_opc_i,
  output logic                                                  r_valid_o,
  output logic [`XBAR_DATA_WIDTH-1:0]                           r_data_o,
  output logic                                                  r_opc_o
);

  localparam periph_xbar_pkg::mst_id_t OWN_ID = periph_xbar_pkg::mst_id_t'(1) << MST_IDX;

  periph_xbar_pkg::xbar_resp_t [`XBAR_NB_SLAVES-1:0] lane_resp;
  logic [`XBAR_NB_SLAVES-1:0]                        match;
  periph_xbar_pkg::slv_idx_t                         lane;

  always_comb begin
    lane = '0;
    for (int s = 0; s < `XBAR_NB_SLAVES; s++) begin
      lane_resp[s] = '{data: r_data_i[s], id: r_id_i[s], opc: r_opc_i[s]};
      match[s]     = r_valid_i[s] && (lane_resp[s].id == OWN_ID);
      // one-hot to binary, OR of the matching lane numbers
      if (match[s]) begin
        lane = lane | periph_xbar_pkg::slv_idx_t'(s);
      end
    end
  end

  assign r_valid_o = |match;
  assign r_data_o  = lane_resp[lane].data;
  assign r_opc_o   = lane_resp[lane].opc;

endmodule

//--- design/periph_xbar.sv
// ----------------------------------------------------------
// zero-cycle crossbar, masters must always accept responses
// slaves must echo the one-hot id from s_id_o with their response
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_xbar (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  logic [5:0]                                        cluster_id_i,

  // master side
  input  logic [`XBAR_NB_MASTERS-1:0]                       m_req_i,
  input  logic [`XBAR_NB_MASTERS-1:0][`XBAR_ADDR_WIDTH-1:0] m_addr_i,
  input  logic [`XBAR_NB_MASTERS-1:0][`XBAR_DATA_WIDTH-1:0] m_wdata_i,
  input  logic [`XBAR_NB_MASTERS-1:0]                       m_we_n_i,
  input  logic [`XBAR_NB_MASTERS-1:0][`XBAR_BE_WIDTH-1:0]   m_be_i,
  output logic [`XBAR_NB_MASTERS-1:0]                       m_gnt_o,
  output logic [`XBAR_NB_MASTERS-1:0]                       m_r_valid_o,
  output logic [`XBAR_NB_MASTERS-1:0][`XBAR_DATA_WIDTH-1:0] m_r_rdata_o,
  output logic [`XBAR_NB_MASTERS-1:0]                       m_r_opc_o,

  // slave side
  output logic [`XBAR_NB_SLAVES-1:0]                        s_req_o,
  output logic [`XBAR_NB_SLAVES-1:0][`XBAR_ADDR_WIDTH-1:0]  s_addr_o,
  output logic [`XBAR_NB_SLAVES-1:0][`XBAR_DATA_WIDTH-1:0]  s_wdata_o,
  output logic [`XBAR_NB_SLAVES-1:0]                        s_we_n_o,
  output logic [`XBAR_NB_SLAVES-1:0][`XBAR_BE_WIDTH-1:0]    s_be_o,
  output logic [`XBAR_NB_SLAVES-1:0][`XBAR_NB_MASTERS-1:0]  s_id_o,
  input  logic [`XBAR_NB_SLAVES-1:0]                        s_gnt_i,
  input  logic [`XBAR_NB_SLAVES-1:0]                        s_r_valid_i,
  input  logic [`XBAR_NB_SLAVES-1:0][`XBAR_DATA_WIDTH-1:0]  s_r_rdata_i,
  input  logic [`XBAR_NB_SLAVES-1:0][`XBAR_NB_MASTERS-1:0]  s_r_id_i,
  input  logic [`XBAR_NB_SLAVES-1:0]                        s_r_opc_i
);

  periph_xbar_pkg::slv_idx_t  [`XBAR_NB_MASTERS-1:0] mst_sel;
  periph_xbar_pkg::xbar_req_t [`XBAR_NB_MASTERS-1:0] mst_req;
  periph_xbar_pkg::xbar_req_t [`XBAR_NB_SLAVES-1:0]  lane_req_data;

  // demux side is master-major, arbiter side lane-major
  logic [`XBAR_NB_MASTERS-1:0][`XBAR_NB_SLAVES-1:0] dmx_req;
  logic [`XBAR_NB_MASTERS-1:0][`XBAR_NB_SLAVES-1:0] dmx_gnt;
  logic [`XBAR_NB_SLAVES-1:0][`XBAR_NB_MASTERS-1:0] lane_req;
  logic [`XBAR_NB_SLAVES-1:0][`XBAR_NB_MASTERS-1:0] lane_gnt;

  for (genvar m = 0; m < `XBAR_NB_MASTERS; m++) begin : gen_mst
    periph_addr_decoder i_dec (
      .addr_i       (m_addr_i[m]),
      .cluster_id_i (cluster_id_i),
      .slv_idx_o    (mst_sel[m])
    );

    // id field tags the request so the response can find its way back
    assign mst_req[m] = '{
      addr: m_addr_i[m],
      data: m_wdata_i[m],
      id:   periph_xbar_pkg::mst_id_t'(1) << m,
      we_n: m_we_n_i[m],
      be:   m_be_i[m]
    };

    req_demux i_demux (
      .req_i (m_req_i[m]),
      .sel_i (mst_sel[m]),
      .req_o (dmx_req[m]),
      .gnt_i (dmx_gnt[m]),
      .gnt_o (m_gnt_o[m])
    );

    resp_mux #(
      .MST_IDX (m)
    ) i_resp (
      .r_valid_i (s_r_valid_i),
      .r_id_i    (s_r_id_i),
      .r_data_i  (s_r_rdata_i),
      .r_opc_i   (s_r_opc_i),
      .r_valid_o (m_r_valid_o[m]),
      .r_data_o  (m_r_rdata_o[m]),
      .r_opc_o   (m_r_opc_o[m])
    );

    for (genvar s = 0; s < `XBAR_NB_SLAVES; s++) begin : gen_xpose
      assign lane_req[s][m] = dmx_req[m][s];
      assign dmx_gnt[m][s]  = lane_gnt[s][m];
    end
  end

  for (genvar s = 0; s < `XBAR_NB_SLAVES; s++) begin : gen_lane
    rr_arbiter #(
      .NUM_IN    (`XBAR_NB_MASTERS),
      .payload_t (periph_xbar_pkg::xbar_req_t)
    ) i_arb (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (lane_req[s]),
      .data_i  (mst_req),
      .gnt_o   (lane_gnt[s]),
      .req_o   (s_req_o[s]),
      .data_o  (lane_req_data[s]),
      .gnt_i   (s_gnt_i[s])
    );

    assign s_addr_o[s]  = lane_req_data[s].addr;
    assign s_wdata_o[s] = lane_req_data[s].data;
    assign s_we_n_o[s]  = lane_req_data[s].we_n;
    assign s_be_o[s]    = lane_req_data[s].be;
    assign s_id_o[s]    = lane_req_data[s].id;
  end

endmodule

//--- tests/periph_slave_model.sv
// ----------------------------------------------------------
// answers every transfer one cycle after its grant, stall_i blocks the grant
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_slave_model #(
  parameter int unsigned SLV_IDX = 0,
  parameter bit          IS_ERR  = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         stall_i,
  input  logic                         req_i,
  input  logic [`XBAR_ADDR_WIDTH-1:0]  addr_i,
  input  logic [`XBAR_DATA_WIDTH-1:0]  wdata_i,
  input  logic                         we_n_i,
  input  logic [`XBAR_BE_WIDTH-1:0]    be_i,
  input  logic [`XBAR_NB_MASTERS-1:0]  id_i,
  output logic                         gnt_o,
  output logic                         r_valid_o,
  output logic [`XBAR_DATA_WIDTH-1:0]  r_rdata_o,
  output logic [`XBAR_NB_MASTERS-1:0]  r_id_o,
  output logic                         r_opc_o
);

  // last transfer of either direction, so we_n shows the direction
  logic [`XBAR_DATA_WIDTH-1:0] last_wdata;
  logic [`XBAR_BE_WIDTH-1:0]   last_be;
  logic                        last_we_n;
  logic [`XBAR_NB_MASTERS-1:0] last_id;

  assign gnt_o = req_i && !stall_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_o  <= 1'b0;
      r_rdata_o  <= '0;
      r_id_o     <= '0;
      r_opc_o    <= 1'b0;
      last_wdata <= '0;
      last_be    <= '0;
      last_we_n  <= 1'b1;
      last_id    <= '0;
    end else begin
      r_valid_o <= gnt_o;
      if (gnt_o) begin
        // slave number on top, low address bits below
        r_rdata_o  <= {8'(SLV_IDX), addr_i[23:0]};
        r_id_o     <= id_i;
        r_opc_o    <= IS_ERR;
        last_wdata <= wdata_i;
        last_be    <= be_i;
        last_we_n  <= we_n_i;
        last_id    <= id_i;
      end
    end
  end

endmodule

//--- tests/periph_xbar_tb.sv
// ----------------------------------------------------------
// directed decode table, round robin bursts, then a random stalled run
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "periph_xbar_cfg.svh"

module periph_xbar_tb;

  localparam int unsigned NM = `XBAR_NB_MASTERS;
  localparam int unsigned NS = `XBAR_NB_SLAVES;
  localparam int unsigned AW = `XBAR_ADDR_WIDTH;
  localparam int unsigned DW = `XBAR_DATA_WIDTH;
  localparam int unsigned BW = `XBAR_BE_WIDTH;
  localparam int unsigned MAX_WAIT = 100;
  localparam int unsigned NB_RAND = 50;
  // outputs are read this long after the falling edge
  localparam int unsigned SAMPLE_DLY = 2;

  typedef struct {
    string         name;
    logic [5:0]    cid;
    int            mst;
    logic [AW-1:0] addr;
    bit            wr;
    logic [DW-1:0] wdata;
    logic [BW-1:0] be;
    int            slot;
  } vec_t;

  logic                  clk;
  logic                  reset;
  logic [5:0]            cluster_id;
  logic [NM-1:0]         m_req;
  logic [NM-1:0][AW-1:0] m_addr;
  logic [NM-1:0][DW-1:0] m_wdata;
  logic [NM-1:0]         m_we_n;
  logic [NM-1:0][BW-1:0] m_be;
  logic [NM-1:0]         m_gnt;
  logic [NM-1:0]         m_r_valid;
  logic [NM-1:0][DW-1:0] m_r_rdata;
  logic [NM-1:0]         m_r_opc;
  logic [NS-1:0]         s_req;
  logic [NS-1:0][AW-1:0] s_addr;
  logic [NS-1:0][DW-1:0] s_wdata;
  logic [NS-1:0]         s_we_n;
  logic [NS-1:0][BW-1:0] s_be;
  logic [NS-1:0][NM-1:0] s_id;
  logic [NS-1:0]         s_gnt;
  logic [NS-1:0]         s_r_valid;
  logic [NS-1:0][DW-1:0] s_r_rdata;
  logic [NS-1:0][NM-1:0] s_r_id;
  logic [NS-1:0]         s_r_opc;
  logic [NS-1:0]         stall;
  logic                  stall_en;
  logic                  sb_en;
  logic [NS-1:0][DW-1:0] last_wdata;
  logic [NS-1:0][BW-1:0] last_be;
  logic [NS-1:0]         last_we_n;
  logic [NS-1:0][NM-1:0] last_id;

  vec_t          tbl[$];
  logic [DW:0]   exp_q [NM][$];
  logic [AW-1:0] rnd_addr [NM][NB_RAND];
  int            rnd_slot [NM][NB_RAND];

  periph_xbar uut (
    .clk_i (clk), .reset_i (reset), .cluster_id_i (cluster_id),
    .m_req_i (m_req), .m_addr_i (m_addr), .m_wdata_i (m_wdata),
    .m_we_n_i (m_we_n), .m_be_i (m_be), .m_gnt_o (m_gnt),
    .m_r_valid_o (m_r_valid), .m_r_rdata_o (m_r_rdata), .m_r_opc_o (m_r_opc),
    .s_req_o (s_req), .s_addr_o (s_addr), .s_wdata_o (s_wdata),
    .s_we_n_o (s_we_n), .s_be_o (s_be), .s_id_o (s_id), .s_gnt_i (s_gnt),
    .s_r_valid_i (s_r_valid), .s_r_rdata_i (s_r_rdata),
    .s_r_id_i (s_r_id), .s_r_opc_i (s_r_opc)
  );

  for (genvar s = 0; s < NS; s++) begin : gen_slv
    periph_slave_model #(
      .SLV_IDX (s),
      .IS_ERR  (s == 7)
    ) i_slv (
      .clk_i (clk), .reset_i (reset), .stall_i (stall[s]), .req_i (s_req[s]),
      .addr_i (s_addr[s]), .wdata_i (s_wdata[s]), .we_n_i (s_we_n[s]),
      .be_i (s_be[s]), .id_i (s_id[s]), .gnt_o (s_gnt[s]),
      .r_valid_o (s_r_valid[s]), .r_rdata_o (s_r_rdata[s]),
      .r_id_o (s_r_id[s]), .r_opc_o (s_r_opc[s])
    );
    assign last_wdata[s] = i_slv.last_wdata;
    assign last_be[s]    = i_slv.last_be;
    assign last_we_n[s]  = i_slv.last_we_n;
    assign last_id[s]    = i_slv.last_id;
  end

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    stall = stall_en ? NS'($urandom) : '0;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // scoreboard for the random run, one response per grant and in order
  always @(negedge clk) begin
    #SAMPLE_DLY;
    for (int m = 0; m < NM; m++) begin
      if (sb_en && m_r_valid[m]) begin
        if (exp_q[m].size() == 0) begin
          abort_run($sformatf("master %0d got a response it never asked for", m));
        end
        check($sformatf("bp_resp_m%0d", m), exp_q[m].pop_front(), {m_r_opc[m], m_r_rdata[m]});
      end
    end
  end

  function automatic vec_t mk_vec(input string name, input logic [5:0] cid, input int mst,
                                  input logic [AW-1:0] addr, input bit wr,
                                  input logic [DW-1:0] wdata, input logic [BW-1:0] be,
                                  input int slot);
    return '{name, cid, mst, addr, wr, wdata, be, slot};
  endfunction

  // in-window route field to the slot that should answer
  function automatic int route_to_slot(input int route);
    if (route == 3) return 2;
    if (route == 6) return 7;
    return route;
  endfunction

  function automatic int outstanding_resps();
    int total;
    total = 0;
    for (int m = 0; m < NM; m++) begin
      total += exp_q[m].size();
    end
    return total;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
  endtask

  // call right after driving on a falling edge
  task automatic wait_grant(input int m, input string what);
    int cyc;
    cyc = 0;
    #SAMPLE_DLY;
    while (!m_gnt[m]) begin
      if (cyc == MAX_WAIT) begin
        abort_run($sformatf("no grant for master %0d within %0d cycles in %s", m, cyc, what));
      end
      @(negedge clk);
      #SAMPLE_DLY;
      cyc++;
    end
  endtask

  task automatic run_vec(input vec_t v);
    logic [DW-1:0] exp_data;
    int            cyc;
    exp_data = {8'(v.slot), v.addr[23:0]};
    @(negedge clk);
    cluster_id     = v.cid;
    m_req[v.mst]   = 1'b1;
    m_addr[v.mst]  = v.addr;
    m_we_n[v.mst]  = !v.wr;
    m_wdata[v.mst] = v.wdata;
    m_be[v.mst]    = v.be;
    wait_grant(v.mst, v.name);
    // a lone requester lights exactly the expected lane
    check({v.name, "_lane"}, NS'(1) << v.slot, s_req);
    @(posedge clk);
    @(negedge clk);
    m_req[v.mst] = 1'b0;
    cyc = 0;
    #SAMPLE_DLY;
    while (m_r_valid == '0) begin
      if (cyc == MAX_WAIT) begin
        abort_run({"no response within 100 cycles in ", v.name});
      end
      @(negedge clk);
      #SAMPLE_DLY;
      cyc++;
    end
    check({v.name, "_valid"}, NM'(1) << v.mst, m_r_valid);
    check({v.name, "_data"}, exp_data, m_r_rdata[v.mst]);
    check({v.name, "_opc"}, v.slot == 7, m_r_opc[v.mst]);
    if (v.wr) begin
      check({v.name, "_wdata"}, v.wdata, last_wdata[v.slot]);
      check({v.name, "_be"}, v.be, last_be[v.slot]);
      check({v.name, "_we_n"}, 1'b0, last_we_n[v.slot]);
      check({v.name, "_id"}, NM'(1) << v.mst, last_id[v.slot]);
    end
  endtask

  // all masters hit slave 0 at once, grants must follow from first
  task automatic burst_check(input string name, input int first);
    int m;
    int cyc;
    @(negedge clk);
    cluster_id = '0;
    for (int k = 0; k < NM; k++) begin
      m_req[k]  = 1'b1;
      m_addr[k] = 32'h1020_0000 + 32'(k * 4);
      m_we_n[k] = 1'b1;
    end
    for (int k = 0; k < NM; k++) begin
      m   = (first + k) % NM;
      cyc = 0;
      #SAMPLE_DLY;
      while (!(s_req[0] && s_gnt[0])) begin
        if (cyc == MAX_WAIT) begin
          abort_run({"slave 0 saw no granted request within 100 cycles in ", name});
        end
        @(negedge clk);
        #SAMPLE_DLY;
        cyc++;
      end
      check($sformatf("%s_id%0d", name, k), NM'(1) << m, s_id[0]);
      check($sformatf("%s_gnt%0d", name, k), NM'(1) << m, m_gnt);
      @(posedge clk);
      @(negedge clk);
      m_req[m] = 1'b0;
    end
  endtask

  task automatic run_master(input int m);
    for (int k = 0; k < NB_RAND; k++) begin
      @(negedge clk);
      m_req[m]  = 1'b1;
      m_addr[m] = rnd_addr[m][k];
      m_we_n[m] = 1'b1;
      wait_grant(m, "the back-pressure run");
      @(posedge clk);
      exp_q[m].push_back({rnd_slot[m][k] == 7, 8'(rnd_slot[m][k]), rnd_addr[m][k][23:0]});
    end
    @(negedge clk);
    m_req[m] = 1'b0;
  endtask

  initial begin
    int route;
    int cyc;
    void'($urandom(6));
    reset      = 1'b1;
    cluster_id = '0;
    m_req      = '0;
    m_addr     = '0;
    m_wdata    = '0;
    m_we_n     = '1;
    m_be       = '0;
    stall      = '0;
    stall_en   = 1'b0;
    sb_en      = 1'b0;

    // name, cluster, master, address, write, wdata, be, expected slot
    tbl.push_back(mk_vec("rd_slot0", 0, 0, 32'h1020_0000, 0, '0, '0, 0));
    tbl.push_back(mk_vec("rd_slot1", 0, 1, 32'h1020_0404, 0, '0, '0, 1));
    tbl.push_back(mk_vec("rd_slot5", 0, 2, 32'h1020_1408, 0, '0, '0, 5));
    tbl.push_back(mk_vec("rd_hwpe", 0, 3, 32'h1020_1000, 0, '0, '0, 4));
    tbl.push_back(mk_vec("rd_eu_fold", 0, 0, 32'h1020_0C10, 0, '0, '0, 2));
    tbl.push_back(mk_vec("rd_ext_direct", 0, 1, 32'h1020_1800, 0, '0, '0, 7));
    tbl.push_back(mk_vec("rd_bit15", 0, 2, 32'h1020_8400, 0, '0, '0, 7));
    tbl.push_back(mk_vec("rd_unused", 0, 3, 32'h1030_0000, 0, '0, '0, 7));
    tbl.push_back(mk_vec("rd_outside", 0, 0, 32'h2000_0100, 0, '0, '0, 6));
    tbl.push_back(mk_vec("rd_alias", 0, 1, 32'h1B20_0400, 0, '0, '0, 1));
    tbl.push_back(mk_vec("wr_slot1", 0, 2, 32'h1020_0420, 1, 32'hA5A5_1234, 4'h6, 1));
    tbl.push_back(mk_vec("reloc_old", 1, 0, 32'h1020_0000, 0, '0, '0, 6));
    tbl.push_back(mk_vec("reloc_slot0", 1, 1, 32'h1060_0000, 0, '0, '0, 0));
    tbl.push_back(mk_vec("reloc_slot1", 1, 2, 32'h1060_0404, 0, '0, '0, 1));
    tbl.push_back(mk_vec("reloc_slot5", 1, 3, 32'h1060_1408, 0, '0, '0, 5));
    tbl.push_back(mk_vec("reloc_hwpe", 1, 0, 32'h1060_1000, 0, '0, '0, 4));
    tbl.push_back(mk_vec("wr_reloc_slot5", 1, 3, 32'h1060_1400, 1, 32'h0BAD_F00D, 4'hF, 5));
    tbl.push_back(mk_vec("wr_ext", 1, 1, 32'h3000_0000, 1, 32'h1357_9BDF, 4'h1, 6));

    apply_reset();
    // nothing requested yet, so every strobe is low
    #SAMPLE_DLY;
    check("idle_s_req", '0, s_req);
    check("idle_m_gnt", '0, m_gnt);
    check("idle_m_r_valid", '0, m_r_valid);
    foreach (tbl[i]) begin
      run_vec(tbl[i]);
    end

    // fresh pointers so the first burst starts at master 0
    apply_reset();
    burst_check("rr_first", 0);
    run_vec(mk_vec("rr_prime_m1", 0, 1, 32'h1020_0010, 0, '0, '0, 0));
    burst_check("rr_second", 2);

    for (int m = 0; m < NM; m++) begin
      for (int k = 0; k < NB_RAND; k++) begin
        route = $urandom_range(7, 0);
        rnd_addr[m][k] = 32'h1020_0000 | (32'(route) << `XBAR_ROUTING_LSB)
                       | ($urandom & 32'h0000_03FC);
        rnd_slot[m][k] = route_to_slot(route);
      end
    end
    repeat (4) @(negedge clk);
    sb_en    = 1'b1;
    stall_en = 1'b1;
    fork
      run_master(0);
      run_master(1);
      run_master(2);
      run_master(3);
    join
    cyc = 0;
    while (outstanding_resps() != 0) begin
      if (cyc == MAX_WAIT) begin
        abort_run("responses of the back-pressure run did not drain within 100 cycles");
      end
      @(negedge clk);
      cyc++;
    end
    stall_en = 1'b0;
    // a late extra response would still hit an empty queue
    repeat (4) @(negedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+design
design/periph_xbar_pkg.sv
design/periph_addr_decoder.sv
design/req_demux.sv
design/rr_arbiter.sv
design/resp_mux.sv
design/periph_xbar.sv
tests/periph_slave_model.sv
tests/periph_xbar_tb.sv
